/* verilog.f */
+incdir+src
+incdir+test
src/issue_pkg.sv
src/int_regfile.sv
src/issue_hazard_unit.sv
src/operand_stage.sv
src/issue_read_operands.sv
test/tb_issue_read_operands.sv

/* Makefile */
# Verilator build and run for the issue and read-operands stage

VERILATOR ?= verilator
TOP       ?= tb_issue_read_operands
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard src/*.svh test/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_issue_ref.svh */
// reference model functions for expected ack, issued bundle and unit valids
`ifndef TB_ISSUE_REF_SVH
`define TB_ISSUE_REF_SVH

// --------------------------------------------------
// source operand rules
// --------------------------------------------------
// clobbered source with usable forward data
function automatic logic ref_src_fwd(fu_t clob, logic fwd_valid);
    return (clob != NONE) && fwd_valid && (clob != CSR);
endfunction

// clobbered source that cannot be forwarded
function automatic logic ref_src_stall(fu_t clob, logic fwd_valid);
    return (clob != NONE) && !(fwd_valid && (clob != CSR));
endfunction

// --------------------------------------------------
// expected acknowledge, same cycle
// --------------------------------------------------
function automatic logic ref_ack(
    issue_entry_t in, logic v, clobber_t clob, fwd_t f1, fwd_t f2,
    commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] cm, logic flu, logic lsu, logic mult_prev
);
    logic stall;
    logic busy;
    logic rd_ok;
    logic ack;
    // zimm replaces rs1, so rs1 cannot stall then
    stall = (!in.use_zimm && ref_src_stall(clob[in.rs1], f1.valid)) ||
            ref_src_stall(clob[in.rs2], f2.valid);
    busy = 1'b0;
    if (in.fu inside {ALU, CTRL_FLOW, CSR, MULT}) busy = !flu;
    if (in.fu inside {LOAD, STORE}) busy = !lsu;
    rd_ok = (clob[in.rd] == NONE);
    // rd written back in this cycle is no WAW hazard
    for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
        if (cm[p].we && (cm[p].waddr == in.rd)) rd_ok = 1'b1;
    end
    ack = v && ((!stall && !busy && rd_ok) || in.ex_valid || (in.fu == NONE));
    if (mult_prev && (in.fu != MULT)) ack = 1'b0;
    return ack;
endfunction

// --------------------------------------------------
// expected ID/EX bundle, one cycle later
// --------------------------------------------------
function automatic fu_data_t ref_fu_data(
    issue_entry_t in, clobber_t clob, fwd_t f1, fwd_t f2,
    logic [`ISSUE_XLEN-1:0] ra, logic [`ISSUE_XLEN-1:0] rb
);
    fu_data_t d;
    d.fu       = in.fu;
    d.operator = in.op;
    d.trans_id = in.trans_id;
    d.imm      = in.result;
    if (in.use_zimm) d.operand_a = {59'd0, in.rs1};
    else if (in.use_pc) d.operand_a = in.pc;
    else if (ref_src_fwd(clob[in.rs1], f1.valid)) d.operand_a = f1.value;
    else d.operand_a = ra;
    // stores and branches keep rs2
    if (in.use_imm && (in.fu != STORE) && (in.fu != CTRL_FLOW)) d.operand_b = in.result;
    else if (ref_src_fwd(clob[in.rs2], f2.valid)) d.operand_b = f2.value;
    else d.operand_b = rb;
    return d;
endfunction

// expected one-hot unit start
function automatic unit_valid_t ref_valid(issue_entry_t in, logic v, logic ack, logic flush);
    unit_valid_t u;
    u = '0;
    if (v && ack && !in.ex_valid && !flush) begin
        u.alu    = (in.fu == ALU);
        u.branch = (in.fu == CTRL_FLOW);
        u.lsu    = (in.fu == LOAD) || (in.fu == STORE);
        u.mult   = (in.fu == MULT);
        u.csr    = (in.fu == CSR);
    end
    return u;
endfunction

`endif

/* test/tb_issue_read_operands.sv */
// testbench top with clock, reset, register shadow, random stimulus, comparison and timeout
`timescale 1ns/1ps
`include "issue_settings.svh"

module tb_issue_read_operands;
    import issue_pkg::*;

    `include "tb_issue_ref.svh"

    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES   = 3000;
    localparam int MAX_CYCLES   = 4 * (RESET_CYCLES + NUM_CYCLES + 4);

    logic                                      clk_i;
    logic                                      rst_ni;
    logic                                      flush_i;
    issue_entry_t                              issue_instr_i;
    logic                                      issue_instr_valid_i;
    logic                                      issue_ack_o;
    clobber_t                                  rd_clobber_i;
    logic [`ISSUE_REG_ADDR_BITS-1:0]           rs1_o;
    logic [`ISSUE_REG_ADDR_BITS-1:0]           rs2_o;
    fwd_t                                      rs1_fwd_i;
    fwd_t                                      rs2_fwd_i;
    logic                                      flu_ready_i;
    logic                                      lsu_ready_i;
    fu_data_t                                  fu_data_o;
    logic [`ISSUE_XLEN-1:0]                    pc_o;
    logic                                      is_compressed_o;
    unit_valid_t                               valid_o;
    commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i;

    // shadow of the architectural registers
    logic [`ISSUE_XLEN-1:0] shadow [0:`ISSUE_NR_REGS-1];
    fu_data_t               exp_fu_data;
    unit_valid_t            exp_valid;
    logic [`ISSUE_XLEN-1:0] exp_pc;
    logic                   exp_compressed;
    int                     cycles;

    issue_read_operands UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // compare and stop on the first mismatch
    task automatic check_value(string name, logic [255:0] got, logic [255:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // quiet inputs with nothing valid
    task automatic idle_inputs();
        flush_i             = 1'b0;
        issue_instr_i       = '0;
        issue_instr_valid_i = 1'b0;
        rd_clobber_i        = '0;
        rs1_fwd_i           = '0;
        rs2_fwd_i           = '0;
        flu_ready_i         = 1'b1;
        lsu_ready_i         = 1'b1;
        commit_i            = '0;
    endtask

    // --------------------------------------------------
    // random stimulus for one cycle
    // --------------------------------------------------
    task automatic drive_random();
        issue_entry_t in;
        in.pc            = {$urandom(), $urandom() & 32'hffff_fffe};
        in.trans_id      = 3'($urandom());
        in.fu            = fu_t'(3'($urandom_range(0, 6)));
        in.op            = fu_op_t'(7'($urandom_range(0, 26)));
        in.rs1           = 5'($urandom());
        in.rs2           = 5'($urandom());
        in.rd            = 5'($urandom());
        in.result        = {$urandom(), $urandom()};
        in.use_imm       = ($urandom_range(0, 3) == 0);
        in.use_zimm      = ($urandom_range(0, 5) == 0);
        in.use_pc        = ($urandom_range(0, 5) == 0);
        in.ex_valid      = ($urandom_range(0, 9) == 0);
        in.is_compressed = 1'($urandom());
        issue_instr_i       = in;
        issue_instr_valid_i = ($urandom_range(0, 99) < 85);
        // sparse clobbers on the registers this instruction touches
        rd_clobber_i = '0;
        if (in.rs1 != 0 && $urandom_range(0, 2) == 0) begin
            rd_clobber_i[in.rs1] = fu_t'(3'($urandom_range(1, 6)));
        end
        if (in.rs2 != 0 && $urandom_range(0, 2) == 0) begin
            rd_clobber_i[in.rs2] = fu_t'(3'($urandom_range(1, 6)));
        end
        if (in.rd != 0 && $urandom_range(0, 3) == 0) begin
            rd_clobber_i[in.rd] = fu_t'(3'($urandom_range(1, 6)));
        end
        rs1_fwd_i   = '{value: {$urandom(), $urandom()}, valid: ($urandom_range(0, 9) < 7)};
        rs2_fwd_i   = '{value: {$urandom(), $urandom()}, valid: ($urandom_range(0, 9) < 7)};
        flu_ready_i = ($urandom_range(0, 99) < 85);
        lsu_ready_i = ($urandom_range(0, 99) < 85);
        flush_i     = ($urandom_range(0, 9) == 0);
        // port 0 often retires rd to hit the WAW bypass
        commit_i[0].we    = ($urandom_range(0, 9) < 6);
        commit_i[0].waddr = ($urandom_range(0, 3) == 0) ? in.rd : 5'($urandom());
        commit_i[0].wdata = {$urandom(), $urandom()};
        commit_i[1].we    = ($urandom_range(0, 9) < 6);
        commit_i[1].waddr = 5'($urandom());
        commit_i[1].wdata = {$urandom(), $urandom()};
        if (commit_i[0].we && commit_i[1].waddr == commit_i[0].waddr) commit_i[1].we = 1'b0;
    endtask

    // --------------------------------------------------
    // comparison at every rising edge
    // --------------------------------------------------
    always @(posedge clk_i) begin
        logic ack_exp;
        if (rst_ni) begin
            ack_exp = ref_ack(issue_instr_i, issue_instr_valid_i, rd_clobber_i, rs1_fwd_i,
                              rs2_fwd_i, commit_i, flu_ready_i, lsu_ready_i, exp_valid.mult);
            check_value("issue_ack_o", 256'(issue_ack_o), 256'(ack_exp));
            check_value("rs1_o", 256'(rs1_o), 256'(issue_instr_i.rs1));
            check_value("rs2_o", 256'(rs2_o), 256'(issue_instr_i.rs2));
            // registered outputs still hold last cycle's values here
            check_value("valid_o", 256'(valid_o), 256'(exp_valid));
            check_value("fu_data_o", 256'(fu_data_o), 256'(exp_fu_data));
            check_value("pc_o", 256'(pc_o), 256'(exp_pc));
            check_value("is_compressed_o", 256'(is_compressed_o), 256'(exp_compressed));
            exp_valid = ref_valid(issue_instr_i, issue_instr_valid_i, ack_exp, flush_i);
            exp_fu_data = ref_fu_data(issue_instr_i, rd_clobber_i, rs1_fwd_i, rs2_fwd_i,
                                      shadow[issue_instr_i.rs1], shadow[issue_instr_i.rs2]);
            exp_pc         = issue_instr_i.pc;
            exp_compressed = issue_instr_i.is_compressed;
            // commit writes land after the reads of this cycle
            for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && commit_i[p].waddr != 0) begin
                    shadow[commit_i[p].waddr] = commit_i[p].wdata;
                end
            end
        end
    end

    // run length guard
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("=== FAIL ===");
            $fatal(1, "simulation timed out after %0d cycles", cycles);
        end
    end

    initial begin
        void'($urandom(32'h9c1cc7ea));
        cycles = 0;
        for (int r = 0; r < `ISSUE_NR_REGS; r++) shadow[r] = '0;
        exp_fu_data    = '{fu: NONE, operator: ADD, default: '0};
        exp_valid      = '0;
        exp_pc         = '0;
        exp_compressed = 1'b0;
        rst_ni = 1'b0;
        idle_inputs();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            drive_random();
            @(negedge clk_i);
        end
        idle_inputs();
        repeat (3) @(negedge clk_i);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* src/issue_read_operands.sv */
// issue and read-operands top, regfile, hazard unit and operand stage
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_read_operands (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  logic                                                 flush_i,
    // scoreboard side
    input  issue_pkg::issue_entry_t                              issue_instr_i,
    input  logic                                                 issue_instr_valid_i,
    output logic                                                 issue_ack_o,
    input  issue_pkg::clobber_t                                  rd_clobber_i,
    output logic [`ISSUE_REG_ADDR_BITS-1:0]                      rs1_o,
    output logic [`ISSUE_REG_ADDR_BITS-1:0]                      rs2_o,
    input  issue_pkg::fwd_t                                      rs1_fwd_i,
    input  issue_pkg::fwd_t                                      rs2_fwd_i,
    // unit side
    input  logic                                                 flu_ready_i,
    input  logic                                                 lsu_ready_i,
    output issue_pkg::fu_data_t                                  fu_data_o,
    output logic [`ISSUE_XLEN-1:0]                               pc_o,
    output logic                                                 is_compressed_o,
    output issue_pkg::unit_valid_t                               valid_o,
    // commit side
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i
);

    logic                   fwd_rs1;
    logic                   fwd_rs2;
    logic                   mult_issued;
    logic [`ISSUE_XLEN-1:0] rdata_a;
    logic [`ISSUE_XLEN-1:0] rdata_b;

    // scoreboard lookup runs in the same cycle
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    int_regfile i_int_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    issue_hazard_unit i_issue_hazard_unit (
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .rd_clobber_i        (rd_clobber_i),
        .rs1_fwd_i           (rs1_fwd_i),
        .rs2_fwd_i           (rs2_fwd_i),
        .commit_i            (commit_i),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .mult_issued_i       (mult_issued),
        .issue_ack_o         (issue_ack_o),
        .fwd_rs1_o           (fwd_rs1),
        .fwd_rs2_o           (fwd_rs2)
    );

    operand_stage i_operand_stage (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .issue_instr_i       (issue_instr_i),
        .issue_ack_i         (issue_ack_o),
        .issue_instr_valid_i (issue_instr_valid_i),
        .fwd_rs1_i           (fwd_rs1),
        .fwd_rs2_i           (fwd_rs2),
        .rs1_fwd_i           (rs1_fwd_i),
        .rs2_fwd_i           (rs2_fwd_i),
        .rdata_a_i           (rdata_a),
        .rdata_b_i           (rdata_b),
        .fu_data_o           (fu_data_o),
        .pc_o                (pc_o),
        .is_compressed_o     (is_compressed_o),
        .valid_o             (valid_o),
        .mult_issued_o       (mult_issued)
    );

endmodule

/* src/operand_stage.sv */
// operand select mux and ID/EX registers with one-hot unit valids and flush
`timescale 1ns/1ps
`include "issue_settings.svh"

module operand_stage (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  issue_pkg::issue_entry_t       issue_instr_i,
    input  logic                          issue_ack_i,
    input  logic                          issue_instr_valid_i,
    input  logic                          fwd_rs1_i,
    input  logic                          fwd_rs2_i,
    input  issue_pkg::fwd_t               rs1_fwd_i,
    input  issue_pkg::fwd_t               rs2_fwd_i,
    input  logic [`ISSUE_XLEN-1:0]        rdata_a_i,
    input  logic [`ISSUE_XLEN-1:0]        rdata_b_i,
    output issue_pkg::fu_data_t           fu_data_o,
    output logic [`ISSUE_XLEN-1:0]        pc_o,
    output logic                          is_compressed_o,
    output issue_pkg::unit_valid_t        valid_o,
    output logic                          mult_issued_o
);
    import issue_pkg::*;

    fu_data_t    fu_data_d;
    unit_valid_t valid_d;

    // --------------------------------------------------
    // operand select
    // --------------------------------------------------
    always_comb begin : operand_mux
        fu_data_d.fu       = issue_instr_i.fu;
        fu_data_d.operator = issue_instr_i.op;
        fu_data_d.trans_id = issue_instr_i.trans_id;
        fu_data_d.imm      = issue_instr_i.result;

        // operand a, zimm over pc over forward over regfile
        if (issue_instr_i.use_zimm) begin
            fu_data_d.operand_a = {{(`ISSUE_XLEN-`ISSUE_ZIMM_BITS){1'b0}},
                                   issue_instr_i.rs1[`ISSUE_ZIMM_BITS-1:0]};
        end else if (issue_instr_i.use_pc) begin
            fu_data_d.operand_a = issue_instr_i.pc;
        end else if (fwd_rs1_i) begin
            fu_data_d.operand_a = rs1_fwd_i.value;
        end else begin
            fu_data_d.operand_a = rdata_a_i;
        end

        // stores and branches keep rs2 in b, their immediate travels in imm
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE) &&
            (issue_instr_i.fu != CTRL_FLOW)) begin
            fu_data_d.operand_b = issue_instr_i.result;
        end else if (fwd_rs2_i) begin
            fu_data_d.operand_b = rs2_fwd_i.value;
        end else begin
            fu_data_d.operand_b = rdata_b_i;
        end
    end

    // --------------------------------------------------
    // unit valids
    // --------------------------------------------------
    always_comb begin : valid_next
        valid_d = '0;
        if (issue_instr_valid_i && issue_ack_i && !issue_instr_i.ex_valid) begin
            case (issue_instr_i.fu)
                ALU:         valid_d.alu    = 1'b1;
                CTRL_FLOW:   valid_d.branch = 1'b1;
                LOAD, STORE: valid_d.lsu    = 1'b1;
                MULT:        valid_d.mult   = 1'b1;
                CSR:         valid_d.csr    = 1'b1;
                default:     valid_d        = '0;
            endcase
        end
        // flushed instruction must not start a unit
        if (flush_i) begin
            valid_d = '0;
        end
    end

    // --------------------------------------------------
    // ID/EX registers
    // --------------------------------------------------
    // data follows the input every cycle, only the valids qualify it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o       <= '{fu: NONE, operator: ADD, default: '0};
            pc_o            <= '0;
            is_compressed_o <= 1'b0;
            valid_o         <= '0;
        end else begin
            fu_data_o       <= fu_data_d;
            pc_o            <= issue_instr_i.pc;
            is_compressed_o <= issue_instr_i.is_compressed;
            valid_o         <= valid_d;
        end
    end

    // fed back to block non-multiplies next cycle
    assign mult_issued_o = valid_o.mult;

    a_valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(valid_o))
        else $error("more than one unit valid at once");

    a_operands_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o != '0) |-> (!$isunknown(fu_data_o.operand_a) && !$isunknown(fu_data_o.operand_b)))
        else $error("unknown operand issued to a unit");

endmodule

/* src/issue_hazard_unit.sv */
// source clobber and forward check, unit busy, WAW check and issue acknowledge
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_hazard_unit (
    input  issue_pkg::issue_entry_t                              issue_instr_i,
    input  logic                                                 issue_instr_valid_i,
    input  issue_pkg::clobber_t                                  rd_clobber_i,
    input  issue_pkg::fwd_t                                      rs1_fwd_i,
    input  issue_pkg::fwd_t                                      rs2_fwd_i,
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                                 flu_ready_i,
    input  logic                                                 lsu_ready_i,
    input  logic                                                 mult_issued_i,
    output logic                                                 issue_ack_o,
    output logic                                                 fwd_rs1_o,
    output logic                                                 fwd_rs2_o
);
    import issue_pkg::*;

    fu_t  rs1_clobber;
    fu_t  rs2_clobber;
    logic stall;
    logic fu_busy;
    logic rd_free;
    logic rd_committing;

    assign rs1_clobber = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_clobber = rd_clobber_i[issue_instr_i.rs2];

    // --------------------------------------------------
    // source operands
    // --------------------------------------------------
    // a clobbered source is taken from the scoreboard if it is there
    // CSR results never come over the forward path
    always_comb begin : source_check
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        // zimm sits in the rs1 slot, nothing to wait on
        if (!issue_instr_i.use_zimm && (rs1_clobber != NONE)) begin
            if (rs1_fwd_i.valid && (rs1_clobber != CSR)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_clobber != NONE) begin
            if (rs2_fwd_i.valid && (rs2_clobber != CSR)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // unit availability
    // --------------------------------------------------
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // WAW on rd
    // --------------------------------------------------
    assign rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);

    // rd retired by commit this very cycle counts as free
    always_comb begin : rd_commit_bypass
        rd_committing = 1'b0;
        for (int unsigned p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // acknowledge
    // --------------------------------------------------
    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall && !fu_busy && (rd_free || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // excepted or unit-less instructions just drain, no unit needed
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // shared result bus is taken by the multiply in flight
        if (mult_issued_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

/* src/int_regfile.sv */
// integer register file, two async read ports, two commit write ports, x0 hardwired
`timescale 1ns/1ps
`include "issue_settings.svh"

module int_regfile (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  logic [`ISSUE_REG_ADDR_BITS-1:0]                      raddr_a_i,
    input  logic [`ISSUE_REG_ADDR_BITS-1:0]                      raddr_b_i,
    output logic [`ISSUE_XLEN-1:0]                               rdata_a_o,
    output logic [`ISSUE_XLEN-1:0]                               rdata_b_o,
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i
);

    // x0 has no storage
    logic [`ISSUE_XLEN-1:0] regs_q [1:`ISSUE_NR_REGS-1];
    logic                   dup_write;

    // --------------------------------------------------
    // write ports
    // --------------------------------------------------
    // higher port index is applied last and wins on a collision
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 1; r < `ISSUE_NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int unsigned p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // --------------------------------------------------
    // read ports
    // --------------------------------------------------
    // combinational, a write shows up in the next cycle
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    // commit should never retire two results to one register in a cycle
    always_comb begin : dup_check
        dup_write = 1'b0;
        for (int unsigned i = 0; i < `ISSUE_NR_COMMIT_PORTS; i++) begin
            for (int unsigned j = i + 1; j < `ISSUE_NR_COMMIT_PORTS; j++) begin
                if (commit_i[i].we && commit_i[j].we && (commit_i[i].waddr != '0) &&
                    (commit_i[i].waddr == commit_i[j].waddr)) begin
                    dup_write = 1'b1;
                end
            end
        end
    end

    a_no_dup_write: assert property (@(posedge clk_i) disable iff (!rst_ni) !dup_write)
        else $error("two commit ports write the same register in one cycle");

endmodule

/* src/issue_pkg.sv */
// unit and operator enums, decoded instruction, forwarding, commit and issue bundles
`include "issue_settings.svh"

package issue_pkg;

    // functional unit an instruction is routed to
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT,
        CSR
    } fu_t;

    // operator subset, ADD first so it is the idle value
    typedef enum logic [6:0] {
        ADD, SUB, XORL, ORL, ANDL, SLL, SRL, SRA, SLTS, SLTU,
        EQ, NE, LTS, GES, JALR,
        LD, LW, SD, SW,
        MUL, MULH, DIV, REM,
        CSR_WRITE, CSR_READ, CSR_SET, CSR_CLEAR
    } fu_op_t;

    // decoded instruction as handed over by the scoreboard
    typedef struct packed {
        logic [`ISSUE_XLEN-1:0]          pc;
        logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id;
        fu_t                             fu;
        fu_op_t                          op;
        logic [`ISSUE_REG_ADDR_BITS-1:0] rs1;
        logic [`ISSUE_REG_ADDR_BITS-1:0] rs2;
        logic [`ISSUE_REG_ADDR_BITS-1:0] rd;
        // sign-extended immediate
        logic [`ISSUE_XLEN-1:0]          result;
        logic                            use_imm;
        logic                            use_zimm;
        logic                            use_pc;
        // instruction already carries an exception
        logic                            ex_valid;
        logic                            is_compressed;
    } issue_entry_t;

    // scoreboard answer for one source register
    typedef struct packed {
        logic [`ISSUE_XLEN-1:0] value;
        logic                   valid;
    } fwd_t;

    // one write from the commit stage
    typedef struct packed {
        logic [`ISSUE_REG_ADDR_BITS-1:0] waddr;
        logic [`ISSUE_XLEN-1:0]          wdata;
        logic                            we;
    } commit_port_t;

    // per register, the unit that will write it next
    typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_t;

    // ID/EX bundle towards the units
    typedef struct packed {
        fu_t                             fu;
        fu_op_t                          operator;
        logic [`ISSUE_XLEN-1:0]          operand_a;
        logic [`ISSUE_XLEN-1:0]          operand_b;
        logic [`ISSUE_XLEN-1:0]          imm;
        logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // one-cycle start pulses, at most one set
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

endpackage

/* src/issue_settings.svh */
// width and count macros for the issue and read-operands stage
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// --------------------------------------------------
// datapath
// --------------------------------------------------
// integer datapath width
`define ISSUE_XLEN 64
// zimm field width, taken from the rs1 slot
`define ISSUE_ZIMM_BITS 5

// --------------------------------------------------
// register file and scoreboard
// --------------------------------------------------
// architectural register address width
`define ISSUE_REG_ADDR_BITS 5
// number of integer registers, x0 included
`define ISSUE_NR_REGS 32
// write ports coming back from commit
`define ISSUE_NR_COMMIT_PORTS 2
// scoreboard transaction id width
`define ISSUE_TRANS_ID_BITS 3

`endif
